// File: source/rchn_pkg.sv
package rchn_pkg;

	// request and bus sizes
	localparam int MAX_RD_BTT = 2048;  // largest request in bytes
	localparam int BTT_W = $clog2(MAX_RD_BTT) + 1;
	localparam int ADDR_W = 32;
	localparam int BEAT_BYTES = 8;
	localparam int DATA_W = BEAT_BYTES * 8;
	localparam int KEEP_ID_W = $clog2(BEAT_BYTES);
	localparam int BEATS_W = $clog2(MAX_RD_BTT / BEAT_BYTES) + 1;

	// burst limits
	localparam int MAX_BURST_LEN = 16;
	localparam int PAGE_BYTES = 4096;
	localparam int PAGE_AW = $clog2(PAGE_BYTES);
	localparam int PAGE_W = PAGE_AW - KEEP_ID_W;  // beat index inside a page

	// outstanding and buffer accounting
	localparam int RADDR_OUTSTANDING = 4;
	localparam int MSG_AW = $clog2(RADDR_OUTSTANDING);
	localparam int OUT_CNT_W = $clog2(RADDR_OUTSTANDING + 1);
	localparam int RDATA_BUF_DEPTH = 64;
	localparam int BUF_AW = $clog2(RDATA_BUF_DEPTH);
	localparam int MAX_STORED_BURSTS = RDATA_BUF_DEPTH / MAX_BURST_LEN;
	localparam int STORE_CNT_W = $clog2(MAX_STORED_BURSTS + 1);

	// fifo word {first id, last id, burst last, request last, data}
	localparam int TAG_W = DATA_W + 2 * KEEP_ID_W + 2;

	typedef enum logic
	{
		BG_IDLE,
		BG_ISSUE
	} burst_state_e;

	typedef enum logic
	{
		RA_PASS,
		RA_FLUSH
	} realign_state_e;

endpackage

// File: source/burst_gen.sv
`timescale 1ns/1ns

module burst_gen import rchn_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [BTT_W+31:0]      rd_req_data_i,  // {byte count, start address}
	input  logic                   rd_req_valid_i,
	output logic                   rd_req_ready_o,
	output logic [ADDR_W-1:0]      m_axi_araddr_o,
	output logic [7:0]             m_axi_arlen_o,
	output logic                   m_axi_arvalid_o,
	input  logic                   m_axi_arready_i,
	input  logic                   issue_ok_i,
	output logic                   burst_push_o,
	output logic                   burst_last_o,
	output logic [KEEP_ID_W-1:0]   first_keep_id_o,
	output logic [KEEP_ID_W-1:0]   last_keep_id_o
);

	burst_state_e state;
	logic [ADDR_W-1:0] cur_addr;       // beat aligned
	logic [BEATS_W-1:0] beats_rem;
	logic [PAGE_W-1:0] page_left_m1;   // beats left in the 4k page, minus one
	logic [BTT_W-1:0] req_btt;
	logic [ADDR_W-1:0] req_addr;
	logic [BTT_W-1:0] end_addr;        // byte count plus unaligned start offset
	logic [BEATS_W-1:0] req_beats;
	logic [BEATS_W-1:0] len_rem;
	logic [BEATS_W-1:0] len_page;
	logic [BEATS_W-1:0] burst_len;
	logic req_hs;
	logic ar_hs;

	assign req_btt = rd_req_data_i[BTT_W+31:32];
	assign req_addr = rd_req_data_i[ADDR_W-1:0];
	assign end_addr = req_btt + BTT_W'(req_addr[KEEP_ID_W-1:0]);
	// round the end up to whole beats
	assign req_beats = end_addr[BTT_W-1:KEEP_ID_W] + BEATS_W'(|end_addr[KEEP_ID_W-1:0]);

	assign req_hs = rd_req_valid_i & rd_req_ready_o;
	assign ar_hs = m_axi_arvalid_o & m_axi_arready_i;

	// burst length is the smallest of remaining, page room and max burst
	assign len_rem = (beats_rem <= MAX_BURST_LEN) ? beats_rem : BEATS_W'(MAX_BURST_LEN);
	assign len_page = (page_left_m1 < MAX_BURST_LEN) ? (page_left_m1 + 1'b1) :
		BEATS_W'(MAX_BURST_LEN);
	assign burst_len = (len_rem < len_page) ? len_rem : len_page;

	assign rd_req_ready_o = (state == BG_IDLE);
	assign m_axi_arvalid_o = (state == BG_ISSUE) & issue_ok_i;
	assign m_axi_araddr_o = cur_addr;
	assign m_axi_arlen_o = 8'(burst_len - 1'b1);

	assign burst_push_o = ar_hs;
	assign burst_last_o = (beats_rem == burst_len);  // everything left fits in this burst

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= BG_IDLE;
		else
		begin
			case (state)
				BG_IDLE:
				begin
					if (req_hs)
						state <= BG_ISSUE;
				end
				BG_ISSUE:
				begin
					if (ar_hs && burst_last_o)
						state <= BG_IDLE;
				end
				default:
					state <= BG_IDLE;
			endcase
		end
	end

	// address walk
	always_ff @(posedge clk)
	begin
		if (req_hs)
		begin
			cur_addr <= {req_addr[ADDR_W-1:KEEP_ID_W], {KEEP_ID_W{1'b0}}};
			beats_rem <= req_beats;
			page_left_m1 <= ~req_addr[PAGE_AW-1:KEEP_ID_W];
		end
		else if (ar_hs)
		begin
			cur_addr <= {cur_addr[ADDR_W-1:KEEP_ID_W] + (ADDR_W-KEEP_ID_W)'(burst_len),
				{KEEP_ID_W{1'b0}}};
			beats_rem <= beats_rem - burst_len;
			page_left_m1 <= page_left_m1 - PAGE_W'(burst_len);  // wraps to 511 on a new page
		end
	end

	// byte lane ids of the first and last beat
	always_ff @(posedge clk)
	begin
		if (req_hs)
		begin
			first_keep_id_o <= req_addr[KEEP_ID_W-1:0];
			last_keep_id_o <= end_addr[KEEP_ID_W-1:0] - 1'b1;
		end
	end

endmodule

// File: source/rdata_buffer.sv
`timescale 1ns/1ns

module rdata_buffer import rchn_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   burst_push_i,
	input  logic                   burst_last_i,
	input  logic [KEEP_ID_W-1:0]   first_keep_id_i,
	input  logic [KEEP_ID_W-1:0]   last_keep_id_i,
	output logic                   issue_ok_o,
	input  logic [DATA_W-1:0]      m_axi_rdata_i,
	input  logic                   m_axi_rlast_i,
	input  logic                   m_axi_rvalid_i,
	output logic                   m_axi_rready_o,
	output logic [DATA_W-1:0]      buf_data_o,
	output logic [BEAT_BYTES-1:0]  buf_keep_o,
	output logic                   buf_last_o,
	output logic                   buf_valid_o,
	input  logic                   buf_ready_i
);

	logic [OUT_CNT_W-1:0] out_cnt;      // bursts in flight
	logic [STORE_CNT_W-1:0] store_cnt;  // bursts reserved in the fifo
	logic [KEEP_ID_W-1:0] msg_fid [RADDR_OUTSTANDING];
	logic [KEEP_ID_W-1:0] msg_lid [RADDR_OUTSTANDING];
	logic msg_last [RADDR_OUTSTANDING];
	logic [MSG_AW-1:0] msg_wptr;
	logic [MSG_AW-1:0] msg_rptr;
	logic [TAG_W-1:0] mem [RDATA_BUF_DEPTH];
	logic [BUF_AW-1:0] wptr;
	logic [BUF_AW-1:0] rptr;
	logic [BUF_AW:0] fill;
	logic [BUF_AW:0] fill_nxt;
	logic [TAG_W-1:0] wr_word;
	logic [TAG_W-1:0] rd_word;
	logic [KEEP_ID_W-1:0] rd_fid;
	logic [KEEP_ID_W-1:0] rd_lid;
	logic rd_burst_last;
	logic rd_first;                     // next beat out opens a request
	logic [BEAT_BYTES-1:0] first_keep;
	logic [BEAT_BYTES-1:0] last_keep;
	logic wr_en;
	logic rd_en;
	logic rlast_hs;
	logic fetch;

	assign wr_en = m_axi_rvalid_i & m_axi_rready_o;
	assign rd_en = buf_valid_o & buf_ready_i;
	assign rlast_hs = wr_en & m_axi_rlast_i;
	assign fetch = rd_en & rd_burst_last;  // releases one reserved burst

	assign issue_ok_o = (out_cnt < RADDR_OUTSTANDING) & (store_cnt < MAX_STORED_BURSTS);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_cnt <= '0;
			store_cnt <= '0;
			msg_wptr <= '0;
			msg_rptr <= '0;
		end
		else
		begin
			if (burst_push_i && !rlast_hs)
				out_cnt <= out_cnt + 1'b1;
			else if (!burst_push_i && rlast_hs)
				out_cnt <= out_cnt - 1'b1;
			if (burst_push_i && !fetch)
				store_cnt <= store_cnt + 1'b1;
			else if (!burst_push_i && fetch)
				store_cnt <= store_cnt - 1'b1;
			if (burst_push_i)
				msg_wptr <= msg_wptr + 1'b1;
			if (rlast_hs)
				msg_rptr <= msg_rptr + 1'b1;
		end
	end

	// per-burst message queue
	always_ff @(posedge clk)
	begin
		if (burst_push_i)
		begin
			msg_fid[msg_wptr] <= first_keep_id_i;
			msg_lid[msg_wptr] <= last_keep_id_i;
			msg_last[msg_wptr] <= burst_last_i;
		end
	end

	assign wr_word = {msg_fid[msg_rptr], msg_lid[msg_rptr], m_axi_rlast_i,
		m_axi_rlast_i & msg_last[msg_rptr], m_axi_rdata_i};

	// data fifo
	assign fill_nxt = fill + (BUF_AW+1)'(wr_en) - (BUF_AW+1)'(rd_en);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wptr <= '0;
			rptr <= '0;
			fill <= '0;
			m_axi_rready_o <= 1'b0;
			rd_first <= 1'b1;
		end
		else
		begin
			if (wr_en)
				wptr <= wptr + 1'b1;
			if (rd_en)
			begin
				rptr <= rptr + 1'b1;
				rd_first <= buf_last_o;
			end
			fill <= fill_nxt;
			m_axi_rready_o <= (fill_nxt != RDATA_BUF_DEPTH);
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wptr] <= wr_word;
	end

	assign rd_word = mem[rptr];
	assign {rd_fid, rd_lid, rd_burst_last, buf_last_o, buf_data_o} = rd_word;
	assign buf_valid_o = (fill != '0);

	// keep from the byte lane ids
	always_comb
	begin
		for (int i = 0; i < BEAT_BYTES; i++)
		begin
			first_keep[i] = (KEEP_ID_W'(i) >= rd_fid);
			last_keep[i] = (KEEP_ID_W'(i) <= rd_lid);
		end
	end

	assign buf_keep_o = (rd_first ? first_keep : {BEAT_BYTES{1'b1}}) &
		(buf_last_o ? last_keep : {BEAT_BYTES{1'b1}});

endmodule

// File: source/byte_realign.sv
`timescale 1ns/1ns

module byte_realign import rchn_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [DATA_W-1:0]      buf_data_i,
	input  logic [BEAT_BYTES-1:0]  buf_keep_i,
	input  logic                   buf_last_i,
	input  logic                   buf_valid_i,
	output logic                   buf_ready_o,
	output logic [DATA_W-1:0]      m_axis_data_o,
	output logic [BEAT_BYTES-1:0]  m_axis_keep_o,
	output logic                   m_axis_last_o,
	output logic                   m_axis_valid_o,
	input  logic                   m_axis_ready_i
);

	realign_state_e state;
	logic first_beat;                     // next input beat opens a packet
	logic [KEEP_ID_W-1:0] shift;          // leading empty bytes of the packet
	logic [KEEP_ID_W-1:0] shift_nxt;
	logic [DATA_W-1:0] hold_data;
	logic [BEAT_BYTES-1:0] hold_keep;
	logic [KEEP_ID_W+2:0] sh_bits;
	logic [KEEP_ID_W+2:0] nxt_bits;
	logic [KEEP_ID_W+3:0] up_bits;
	logic [KEEP_ID_W:0] up_bytes;
	logic one_beat;
	logic leftover;                       // last beat has bytes that do not fit
	logic in_hs;

	// lowest enabled byte lane of the incoming beat
	always_comb
	begin
		shift_nxt = '0;
		for (int i = BEAT_BYTES - 1; i >= 0; i--)
		begin
			if (buf_keep_i[i])
				shift_nxt = KEEP_ID_W'(i);
		end
	end

	assign sh_bits = {shift, 3'b000};
	assign nxt_bits = {shift_nxt, 3'b000};
	assign up_bits = (KEEP_ID_W+4)'(DATA_W) - {1'b0, sh_bits};
	assign up_bytes = (KEEP_ID_W+1)'(BEAT_BYTES) - {1'b0, shift};

	assign one_beat = first_beat & buf_last_i;
	assign leftover = |(buf_keep_i & ({BEAT_BYTES{1'b1}} << shift));
	assign buf_ready_o = (state == RA_PASS) & m_axis_ready_i;
	assign in_hs = buf_valid_i & buf_ready_o;

	always_comb
	begin
		if (state == RA_FLUSH)
		begin
			m_axis_data_o = hold_data >> sh_bits;  // tail of the last beat
			m_axis_keep_o = hold_keep >> shift;
			m_axis_last_o = 1'b1;
			m_axis_valid_o = 1'b1;
		end
		else if (one_beat)
		begin
			m_axis_data_o = buf_data_i >> nxt_bits;
			m_axis_keep_o = buf_keep_i >> shift_nxt;
			m_axis_last_o = 1'b1;
			m_axis_valid_o = buf_valid_i;
		end
		else
		begin
			m_axis_data_o = (hold_data >> sh_bits) | (buf_data_i << up_bits);
			m_axis_keep_o = (hold_keep >> shift) | (buf_keep_i << up_bytes);
			m_axis_last_o = buf_last_i & ~leftover;
			m_axis_valid_o = buf_valid_i & ~first_beat;  // first beat only fills the holder
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= RA_PASS;
			first_beat <= 1'b1;
		end
		else
		begin
			if (in_hs)
				first_beat <= buf_last_i;
			case (state)
				RA_PASS:
				begin
					if (in_hs && buf_last_i && !first_beat && leftover)
						state <= RA_FLUSH;
				end
				RA_FLUSH:
				begin
					if (m_axis_ready_i)
						state <= RA_PASS;
				end
				default:
					state <= RA_PASS;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (in_hs && first_beat)
			shift <= shift_nxt;
		if (in_hs)
		begin
			hold_data <= buf_data_i;
			hold_keep <= buf_keep_i;
		end
	end

endmodule

// File: source/conv_in_rchn.sv
`timescale 1ns/1ns

module conv_in_rchn import rchn_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	// read request
	input  logic [BTT_W+31:0]      rd_req_data_i,
	input  logic                   rd_req_valid_i,
	output logic                   rd_req_ready_o,
	// axi read address
	output logic [ADDR_W-1:0]      m_axi_araddr_o,
	output logic [7:0]             m_axi_arlen_o,
	output logic                   m_axi_arvalid_o,
	input  logic                   m_axi_arready_i,
	// axi read data
	input  logic [DATA_W-1:0]      m_axi_rdata_i,
	input  logic                   m_axi_rlast_i,
	input  logic                   m_axi_rvalid_i,
	output logic                   m_axi_rready_o,
	// realigned stream out
	output logic [DATA_W-1:0]      m_axis_data_o,
	output logic [BEAT_BYTES-1:0]  m_axis_keep_o,
	output logic                   m_axis_last_o,
	output logic                   m_axis_valid_o,
	input  logic                   m_axis_ready_i
);

	logic issue_ok;
	logic burst_push;
	logic burst_last;
	logic [KEEP_ID_W-1:0] first_keep_id;
	logic [KEEP_ID_W-1:0] last_keep_id;
	logic [DATA_W-1:0] buf_data;
	logic [BEAT_BYTES-1:0] buf_keep;
	logic buf_last;
	logic buf_valid;
	logic buf_ready;

	burst_gen i_burst_gen
	(
		.clk              (clk),
		.rst_n            (rst_n),
		.rd_req_data_i    (rd_req_data_i),
		.rd_req_valid_i   (rd_req_valid_i),
		.rd_req_ready_o   (rd_req_ready_o),
		.m_axi_araddr_o   (m_axi_araddr_o),
		.m_axi_arlen_o    (m_axi_arlen_o),
		.m_axi_arvalid_o  (m_axi_arvalid_o),
		.m_axi_arready_i  (m_axi_arready_i),
		.issue_ok_i       (issue_ok),
		.burst_push_o     (burst_push),
		.burst_last_o     (burst_last),
		.first_keep_id_o  (first_keep_id),
		.last_keep_id_o   (last_keep_id)
	);

	rdata_buffer i_rdata_buffer
	(
		.clk              (clk),
		.rst_n            (rst_n),
		.burst_push_i     (burst_push),
		.burst_last_i     (burst_last),
		.first_keep_id_i  (first_keep_id),
		.last_keep_id_i   (last_keep_id),
		.issue_ok_o       (issue_ok),
		.m_axi_rdata_i    (m_axi_rdata_i),
		.m_axi_rlast_i    (m_axi_rlast_i),
		.m_axi_rvalid_i   (m_axi_rvalid_i),
		.m_axi_rready_o   (m_axi_rready_o),
		.buf_data_o       (buf_data),
		.buf_keep_o       (buf_keep),
		.buf_last_o       (buf_last),
		.buf_valid_o      (buf_valid),
		.buf_ready_i      (buf_ready)
	);

	byte_realign i_byte_realign
	(
		.clk              (clk),
		.rst_n            (rst_n),
		.buf_data_i       (buf_data),
		.buf_keep_i       (buf_keep),
		.buf_last_i       (buf_last),
		.buf_valid_i      (buf_valid),
		.buf_ready_o      (buf_ready),
		.m_axis_data_o    (m_axis_data_o),
		.m_axis_keep_o    (m_axis_keep_o),
		.m_axis_last_o    (m_axis_last_o),
		.m_axis_valid_o   (m_axis_valid_o),
		.m_axis_ready_i   (m_axis_ready_i)
	);

endmodule

// File: testbench/conv_in_rchn_chk.sv
`timescale 1ns/1ns

module conv_in_rchn_chk import rchn_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [ADDR_W-1:0]      m_axi_araddr_o,
	input  logic [7:0]             m_axi_arlen_o,
	input  logic                   m_axi_arvalid_o,
	input  logic                   m_axi_arready_i,
	input  logic [DATA_W-1:0]      m_axis_data_o,
	input  logic [BEAT_BYTES-1:0]  m_axis_keep_o,
	input  logic                   m_axis_last_o,
	input  logic                   m_axis_valid_o,
	input  logic                   m_axis_ready_i
);

	// stalled AR keeps valid, address and length
	ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		m_axi_arvalid_o && !m_axi_arready_i |=> m_axi_arvalid_o &&
		$stable(m_axi_araddr_o) && $stable(m_axi_arlen_o))
		else $error("AR channel changed while stalled");

	ar_page: assert property (@(posedge clk) disable iff (!rst_n)
		m_axi_arvalid_o |-> (int'(m_axi_araddr_o[PAGE_AW-1:0]) +
		(int'(m_axi_arlen_o) + 1) * BEAT_BYTES <= PAGE_BYTES))
		else $error("burst crosses a 4k page");

	ar_len: assert property (@(posedge clk) disable iff (!rst_n)
		m_axi_arvalid_o |-> int'(m_axi_arlen_o) < MAX_BURST_LEN)
		else $error("burst longer than the maximum");

	out_hold: assert property (@(posedge clk) disable iff (!rst_n)
		m_axis_valid_o && !m_axis_ready_i |=> m_axis_valid_o &&
		$stable(m_axis_data_o) && $stable(m_axis_keep_o) && $stable(m_axis_last_o))
		else $error("output stream changed while stalled");

endmodule

bind conv_in_rchn conv_in_rchn_chk i_chk (.*);

// File: testbench/tb_conv_in_rchn.sv
`timescale 1ns/1ns

module tb_conv_in_rchn import rchn_pkg::*;
();

	logic clk;
	logic rst_n;
	logic [BTT_W+31:0] rd_req_data;
	logic rd_req_valid;
	logic rd_req_ready;
	logic [ADDR_W-1:0] araddr;
	logic [7:0] arlen;
	logic arvalid;
	logic arready;
	logic [DATA_W-1:0] rdata;
	logic rlast;
	logic rvalid;
	logic rready;
	logic [DATA_W-1:0] out_data;
	logic [BEAT_BYTES-1:0] out_keep;
	logic out_last;
	logic out_valid;
	logic out_ready;

	logic [31:0] trace_mem [128];     // 4 words per request
	int nreq;
	logic [ADDR_W-1:0] ar_q [$];      // bursts waiting for read data
	int len_q [$];
	int beat_idx;
	int seed;
	int errors;
	int pkt;                          // packet being collected
	int pkt_beat;
	logic req_taken;
	logic [ADDR_W-1:0] exp_araddr;    // next burst address of the request

	conv_in_rchn i_dut
	(
		.clk              (clk),
		.rst_n            (rst_n),
		.rd_req_data_i    (rd_req_data),
		.rd_req_valid_i   (rd_req_valid),
		.rd_req_ready_o   (rd_req_ready),
		.m_axi_araddr_o   (araddr),
		.m_axi_arlen_o    (arlen),
		.m_axi_arvalid_o  (arvalid),
		.m_axi_arready_i  (arready),
		.m_axi_rdata_i    (rdata),
		.m_axi_rlast_i    (rlast),
		.m_axi_rvalid_i   (rvalid),
		.m_axi_rready_o   (rready),
		.m_axis_data_o    (out_data),
		.m_axis_keep_o    (out_keep),
		.m_axis_last_o    (out_last),
		.m_axis_valid_o   (out_valid),
		.m_axis_ready_i   (out_ready)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic report_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		$display("FAIL %s: expected %0h, actual %0h", name, exp, act);
		errors++;
	endtask

	// memory model returning the low address byte in every byte lane
	task automatic drive_rdata(input logic r_fire);
		logic [ADDR_W-1:0] beat_addr;
		if (r_fire || !rvalid)
		begin
			if (ar_q.size() > 0 && ($random(seed) & 3) != 0)
			begin
				beat_addr = ar_q[0] + ADDR_W'(BEAT_BYTES * beat_idx);
				for (int j = 0; j < BEAT_BYTES; j++)
					rdata[8*j +: 8] = 8'(beat_addr + ADDR_W'(j));
				rlast = (beat_idx == len_q[0] - 1);
				rvalid = 1'b1;
			end
			else
			begin
				rvalid = 1'b0;  // gap
				rlast = 1'b0;
			end
		end
	endtask

	task automatic check_out_beat(input logic [DATA_W-1:0] data, input logic [BEAT_BYTES-1:0] keep,
		input logic last);
		int b;
		logic [7:0] exp_byte;
		logic [BEAT_BYTES-1:0] keep_exp;
		logic last_exp;
		string name;
		if (pkt >= nreq)
		begin
			$display("output beat seen after every request was complete");
			errors++;
		end
		else
		begin
			name = $sformatf("req%0d beat %0d", pkt, pkt_beat);
			last_exp = (pkt_beat == int'(trace_mem[4*pkt+2]) - 1);
			keep_exp = last_exp ? trace_mem[4*pkt+3][BEAT_BYTES-1:0] : '1;
			if (keep !== keep_exp)
				report_mismatch({name, " keep"}, 64'(keep_exp), 64'(keep));
			if (last !== last_exp)
				report_mismatch({name, " last"}, 64'(last_exp), 64'(last));
			for (int j = 0; j < BEAT_BYTES; j++)
			begin
				b = pkt_beat * BEAT_BYTES + j;
				exp_byte = 8'(trace_mem[4*pkt] + 32'(b));
				if (keep[j] && b < int'(trace_mem[4*pkt+1]) && data[8*j +: 8] !== exp_byte)
					report_mismatch($sformatf("%s byte %0d", name, j), 64'(exp_byte),
						64'(data[8*j +: 8]));
			end
			pkt_beat++;
			if (last)
			begin
				if (pkt_beat != int'(trace_mem[4*pkt+2]))
					report_mismatch($sformatf("req%0d beat count", pkt),
						64'(trace_mem[4*pkt+2]), 64'(pkt_beat));
				pkt++;
				pkt_beat = 0;
			end
		end
	endtask

	// sample handshakes mid cycle, act on them after the edge
	task automatic run_cycle();
		logic req_fire;
		logic ar_fire;
		logic r_fire;
		logic out_fire;
		logic [ADDR_W-1:0] req_a;
		logic [ADDR_W-1:0] ar_a;
		logic [7:0] ar_l;
		logic [DATA_W-1:0] o_data;
		logic [BEAT_BYTES-1:0] o_keep;
		logic o_last;
		@(negedge clk);
		req_fire = rd_req_valid & rd_req_ready;
		ar_fire = arvalid & arready;
		r_fire = rvalid & rready;
		out_fire = out_valid & out_ready;
		req_a = rd_req_data[ADDR_W-1:0];
		ar_a = araddr;
		ar_l = arlen;
		o_data = out_data;
		o_keep = out_keep;
		o_last = out_last;
		@(posedge clk);
		#10;
		if (req_fire)
		begin
			rd_req_valid = 1'b0;
			req_taken = 1'b1;
			exp_araddr = {req_a[ADDR_W-1:KEEP_ID_W], {KEEP_ID_W{1'b0}}};
		end
		if (ar_fire)
		begin
			// bursts of a request are contiguous from the aligned start
			if (ar_a !== exp_araddr)
				report_mismatch("araddr", 64'(exp_araddr), 64'(ar_a));
			exp_araddr = exp_araddr + ADDR_W'(BEAT_BYTES * (int'(ar_l) + 1));
			ar_q.push_back(ar_a);
			len_q.push_back(int'(ar_l) + 1);
		end
		if (r_fire)
		begin
			beat_idx++;
			if (beat_idx == len_q[0])
			begin
				void'(ar_q.pop_front());
				void'(len_q.pop_front());
				beat_idx = 0;
			end
		end
		if (out_fire)
			check_out_beat(o_data, o_keep, o_last);
		drive_rdata(r_fire);
		arready = ($random(seed) & 3) != 0;
		out_ready = ($random(seed) & 3) != 0;  // output stalls
	endtask

	initial
	begin
		int k;
		int wait_cnt;
		logic timed_out;
		seed = 32'hbc66694f;
		errors = 0;
		nreq = 0;
		pkt = 0;
		pkt_beat = 0;
		beat_idx = 0;
		exp_araddr = '0;
		timed_out = 1'b0;
		rst_n = 1'b0;
		rd_req_data = '0;
		rd_req_valid = 1'b0;
		arready = 1'b0;
		rdata = '0;
		rlast = 1'b0;
		rvalid = 1'b0;
		out_ready = 1'b0;
		foreach (trace_mem[i])
			trace_mem[i] = '0;
		$readmemh("testbench/rchn_trace.txt", trace_mem);
		while (nreq < 32 && trace_mem[4*nreq+1] != 0)
			nreq++;
		if (nreq == 0)
		begin
			$display("trace file holds no requests");
			errors++;
		end

		repeat (4) @(posedge clk);
		@(negedge clk);
		if (arvalid !== 1'b0)
			report_mismatch("reset arvalid", 64'(0), 64'(arvalid));
		if (rready !== 1'b0)
			report_mismatch("reset rready", 64'(0), 64'(rready));
		if (out_valid !== 1'b0)
			report_mismatch("reset out valid", 64'(0), 64'(out_valid));
		if (rd_req_ready !== 1'b1)
			report_mismatch("reset req ready", 64'(1), 64'(rd_req_ready));
		@(posedge clk);
		#10 rst_n = 1'b1;

		for (k = 0; k < nreq; k++)
		begin
			rd_req_data = {BTT_W'(trace_mem[4*k+1]), trace_mem[4*k]};
			rd_req_valid = 1'b1;
			req_taken = 1'b0;
			wait_cnt = 0;
			while (!req_taken && wait_cnt < 5000)
			begin
				run_cycle();
				wait_cnt++;
			end
			if (!req_taken)
			begin
				$display("request %0d was never accepted", k);
				errors++;
				timed_out = 1'b1;
				break;
			end
		end

		wait_cnt = 0;
		while (!timed_out && pkt < nreq && wait_cnt < 20000)
		begin
			run_cycle();
			wait_cnt++;
		end
		if (!timed_out && pkt < nreq)
		begin
			$display("only %0d of %0d packets came out before the timeout", pkt, nreq);
			errors++;
		end
		else if (!timed_out)
			repeat (50) run_cycle();  // catch stray beats

		$display("requests %0d, packets %0d, errors %0d", nreq, pkt, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: testbench/rchn_trace.txt
// columns, all hex: start address, byte count, expected output beats, expected last keep
// a zero byte count ends the list
00001000 200 40 ff  // aligned, four full bursts
00002000 12c 26 0f  // aligned, short last burst
00003003 064 0d 0f  // unaligned, flush beat
00003205 014 03 0f  // unaligned, no flush
00003307 042 09 03  // unaligned, no flush
00004f40 190 32 ff  // crosses a 4k page
00005ffb 015 03 1f  // one beat left in the page
00006000 001 01 01  // single byte
00006007 001 01 01  // single byte in the top lane
00006101 007 01 7f  // seven bytes inside one beat
00006203 003 01 07
00006306 004 01 0f  // short request over two beats
00007004 800 100 ff // largest request
00008ff0 020 04 ff  // aligned page crossing
0000a011 0b5 17 1f
0000b00e 02a 06 03
0000c7fd 010 02 ff
0000d000 009 02 01
0000dffe 100 20 ff  // unaligned page crossing

// File: vlog.f
source/rchn_pkg.sv
source/burst_gen.sv
source/rdata_buffer.sv
source/byte_realign.sv
source/conv_in_rchn.sv
testbench/conv_in_rchn_chk.sv
testbench/tb_conv_in_rchn.sv

// File: run_sim.sh
#!/bin/sh
# build and run the conv_in_rchn testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_in_rchn -f vlog.f \
	&& ./obj_dir/Vtb_conv_in_rchn 2>&1 | tee sim.log \
	|| { echo "build or run failed"; exit 1; }
grep -q "Test FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Test OK" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"
exit 0
